// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] wordT;
    typedef logic [4:0] regIdxT;

    // Memory sizes in words
    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;

    typedef logic [$clog2(imemDepth)-1:0] imemAddrT;
    typedef logic [$clog2(dmemDepth)-1:0] dmemAddrT;

    // Major opcodes of the supported subset
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opOp = 7'b0110011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal = 7'b1101111;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;
    localparam logic [2:0] f3Word = 3'b010;
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    localparam logic [6:0] f7Sub = 7'b0100000;

endpackage

`default_nettype wire

// File: ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluPassB
    } aluOpT;

    // Immediate layouts
    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immJ,
        immU
    } immSrcT;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPc4
    } resultSrcT;

endpackage

`default_nettype wire

// File: ctrlIf.sv
`default_nettype none

interface ctrlIf;
    import ctrlPkg::*;

    logic regWrite;
    logic memWrite;
    aluOpT aluOp;
    logic aluSrc;
    resultSrcT resultSrc;
    logic branch;
    logic branchNe;
    logic jump;

    modport decoder (
        output regWrite, memWrite, aluOp, aluSrc, resultSrc, branch, branchNe, jump
    );
    modport pc (input branch, branchNe, jump);
    modport alu (input aluOp);
    modport regfile (input regWrite);
    modport dmem (input memWrite);

endinterface

`default_nettype wire

// File: programCounter.sv
`default_nettype none

module programCounter (
    input logic clk,
    input logic arstN,
    input logic run,
    ctrlIf.pc ctrl,
    input logic zero,
    input cpuPkg::wordT imm,
    output cpuPkg::wordT pc,
    output cpuPkg::wordT pcPlus4
);
    import cpuPkg::*;

    logic taken;
    wordT pcNext;

    assign pcPlus4 = pc + 32'd4;

    // bne inverts the sense of the zero flag
    assign taken = ctrl.jump | (ctrl.branch & (zero ^ ctrl.branchNe));
    assign pcNext = taken ? pc + imm : pcPlus4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: instrMem.sv
`default_nettype none

module instrMem (
    input logic clk,
    input logic we,
    input cpuPkg::imemAddrT wAddr,
    input cpuPkg::wordT wData,
    input cpuPkg::wordT pc,
    output cpuPkg::wordT instr
);
    import cpuPkg::*;

    wordT mem [imemDepth];
    imemAddrT rAddr;

    // Word index without the byte offset
    assign rAddr = pc[$bits(imemAddrT)+1:2];

    // Load port used only while the core is idle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
    end

    assign instr = mem[rAddr];

endmodule

`default_nettype wire

// File: instrDecoder.sv
`default_nettype none

module instrDecoder (
    input logic run,
    input cpuPkg::wordT instr,
    ctrlIf.decoder ctrl,
    output cpuPkg::wordT imm
);
    import cpuPkg::*;
    import ctrlPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic regWriteDec;
    logic memWriteDec;
    immSrcT immSrc;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        // Anything unrecognised falls through as a nop
        regWriteDec = 1'b0;
        memWriteDec = 1'b0;
        ctrl.aluOp = aluAdd;
        ctrl.aluSrc = 1'b0;
        ctrl.resultSrc = resAlu;
        ctrl.branch = 1'b0;
        ctrl.branchNe = 1'b0;
        ctrl.jump = 1'b0;
        immSrc = immI;
        case (opcode)
            opLui: begin
                regWriteDec = 1'b1;
                ctrl.aluOp = aluPassB;
                ctrl.aluSrc = 1'b1;
                immSrc = immU;
            end
            opOpImm: begin
                regWriteDec = (funct3 == f3AddSub);
                ctrl.aluSrc = 1'b1;
            end
            opOp: begin
                regWriteDec = 1'b1;
                case (funct3)
                    f3AddSub: ctrl.aluOp = (funct7 == f7Sub) ? aluSub : aluAdd;
                    f3Slt: ctrl.aluOp = aluSlt;
                    f3And: ctrl.aluOp = aluAnd;
                    f3Or: ctrl.aluOp = aluOr;
                    default: regWriteDec = 1'b0;
                endcase
            end
            opLoad: begin
                regWriteDec = (funct3 == f3Word);
                ctrl.aluSrc = 1'b1;
                ctrl.resultSrc = resMem;
            end
            opStore: begin
                memWriteDec = (funct3 == f3Word);
                ctrl.aluSrc = 1'b1;
                immSrc = immS;
            end
            opBranch: begin
                // Compare by subtraction and let the zero flag decide
                ctrl.aluOp = aluSub;
                immSrc = immB;
                ctrl.branch = (funct3 == f3Beq) || (funct3 == f3Bne);
                ctrl.branchNe = (funct3 == f3Bne);
            end
            opJal: begin
                regWriteDec = 1'b1;
                ctrl.jump = 1'b1;
                ctrl.resultSrc = resPc4;
                immSrc = immJ;
            end
            default: begin
            end
        endcase
    end

    // No state changes while the core is idle
    assign ctrl.regWrite = run & regWriteDec;
    assign ctrl.memWrite = run & memWriteDec;

    always_comb begin
        case (immSrc)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            immU: imm = {instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
    ctrlIf.alu ctrl,
    input cpuPkg::wordT a,
    input cpuPkg::wordT b,
    output cpuPkg::wordT y,
    output logic zero
);
    import cpuPkg::*;
    import ctrlPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (ctrl.aluOp)
            aluAdd: y = a + b;
            aluSub: y = a - b;
            aluAnd: y = a & b;
            aluOr: y = a | b;
            aluSlt: y = {{(xlen-1){1'b0}}, lessThan};
            // lui passes the shifted immediate straight through
            aluPassB: y = b;
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

`default_nettype wire

// File: regFile.sv
`default_nettype none

module regFile (
    input logic clk,
    input logic arstN,
    ctrlIf.regfile ctrl,
    input cpuPkg::regIdxT rs1,
    input cpuPkg::regIdxT rs2,
    input cpuPkg::regIdxT rd,
    input cpuPkg::wordT wd,
    output cpuPkg::wordT rd1,
    output cpuPkg::wordT rd2,
    output cpuPkg::wordT a0
);
    import cpuPkg::*;

    localparam regIdxT a0Idx = 5'd10;

    wordT regs [32];

    // x0 is never written, so it stays zero from reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && (rd != '0)) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];
    assign a0 = regs[a0Idx];

endmodule

`default_nettype wire

// File: dataMem.sv
`default_nettype none

module dataMem (
    input logic clk,
    ctrlIf.dmem ctrl,
    input cpuPkg::wordT addr,
    input cpuPkg::wordT wd,
    output cpuPkg::wordT rd
);
    import cpuPkg::*;

    wordT mem [dmemDepth];
    dmemAddrT idx;

    // Word accesses only
    assign idx = addr[$bits(dmemAddrT)+1:2];

    always_ff @(posedge clk) begin
        if (ctrl.memWrite) begin
            mem[idx] <= wd;
        end
    end

    assign rd = mem[idx];

endmodule

`default_nettype wire

// File: rvCore.sv
`default_nettype none

module rvCore (
    input logic clk,
    input logic arstN,
    input logic run,
    input logic imemWe,
    input cpuPkg::imemAddrT imemAddr,
    input cpuPkg::wordT imemData,
    output cpuPkg::wordT pc,
    output cpuPkg::wordT a0
);
    import cpuPkg::*;
    import ctrlPkg::*;

    ctrlIf ctrl ();

    wordT instr;
    wordT imm;
    wordT pcPlus4;
    wordT rd1;
    wordT rd2;
    wordT aluB;
    wordT aluY;
    wordT readData;
    wordT result;
    logic zero;
    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];

    // Operand B and write-back selection
    assign aluB = ctrl.aluSrc ? imm : rd2;

    always_comb begin
        case (ctrl.resultSrc)
            resMem: result = readData;
            resPc4: result = pcPlus4;
            default: result = aluY;
        endcase
    end

    programCounter u_programCounter (
        .clk(clk),
        .arstN(arstN),
        .run(run),
        .ctrl(ctrl),
        .zero(zero),
        .imm(imm),
        .pc(pc),
        .pcPlus4(pcPlus4)
    );

    instrMem u_instrMem (
        .clk(clk),
        .we(imemWe),
        .wAddr(imemAddr),
        .wData(imemData),
        .pc(pc),
        .instr(instr)
    );

    instrDecoder u_instrDecoder (
        .run(run),
        .instr(instr),
        .ctrl(ctrl),
        .imm(imm)
    );

    alu u_alu (
        .ctrl(ctrl),
        .a(rd1),
        .b(aluB),
        .y(aluY),
        .zero(zero)
    );

    regFile u_regFile (
        .clk(clk),
        .arstN(arstN),
        .ctrl(ctrl),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .wd(result),
        .rd1(rd1),
        .rd2(rd2),
        .a0(a0)
    );

    dataMem u_dataMem (
        .clk(clk),
        .ctrl(ctrl),
        .addr(aluY),
        .wd(rd2),
        .rd(readData)
    );

endmodule

`default_nettype wire

// File: rvCoreTb.sv
`default_nettype none

module rvCoreTb;
    import cpuPkg::*;

    localparam string goldenFile = "program_golden.txt";
    localparam int maxLines = 512;
    localparam int runTimeout = 200;

    logic clk;
    logic arstN;
    logic run;
    logic imemWe;
    imemAddrT imemAddr;
    wordT imemData;
    wordT pc;
    wordT a0;

    // Program words and the per-cycle expected trace
    wordT progQ[$];
    wordT expPcQ[$];
    wordT expA0Q[$];

    rvCore u_rvCore (
        .clk(clk),
        .arstN(arstN),
        .run(run),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .pc(pc),
        .a0(a0)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failWith(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT exp, input wordT got);
        if (got !== exp) begin
            failWith($sformatf("error %s expected %08h got %08h", name, exp, got));
        end
    endtask

    task automatic checkPc(input wordT exp, input wordT got);
        if (got !== exp) begin
            failWith($sformatf("error pc expected %08h got %08h", exp, got));
        end
    endtask

    // P lines carry program words, E lines an expected pc and a0 pair
    task automatic readGolden();
        int fd;
        int lineCount;
        int n;
        string line;
        logic [7:0] tag;
        wordT v1;
        wordT v2;
        fd = $fopen(goldenFile, "r");
        if (fd == 0) begin
            failWith("could not open the golden file");
        end
        lineCount = 0;
        while (!$feof(fd) && lineCount < maxLines) begin
            lineCount++;
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                v1 = '0;
                v2 = '0;
                n = $sscanf(line, "%c %h %h", tag, v1, v2);
                if (tag == "P" && n >= 2) begin
                    progQ.push_back(v1);
                end else if (tag == "E" && n == 3) begin
                    expPcQ.push_back(v1);
                    expA0Q.push_back(v2);
                end else begin
                    failWith("golden file has a line that is neither a program word nor a trace");
                end
            end
        end
        if (!$feof(fd)) begin
            failWith("golden file did not end within the line limit");
        end
        $fclose(fd);
    endtask

    initial begin
        int cycles;
        int idx;
        arstN = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;

        readGolden();
        if (progQ.size() == 0 || expPcQ.size() == 0) begin
            failWith("golden file holds no program or no trace");
        end
        if (progQ.size() > imemDepth) begin
            failWith("program does not fit the instruction memory");
        end

        repeat (8) @(negedge clk);
        arstN = 1'b1;

        // Core idle during the load, so pc and a0 must stay at zero
        for (int i = 0; i < progQ.size(); i++) begin
            imemWe = 1'b1;
            imemAddr = imemAddrT'(i);
            imemData = progQ[i];
            @(negedge clk);
            checkPc(32'h0, pc);
            checkWord("a0", 32'h0, a0);
        end
        imemWe = 1'b0;
        run = 1'b1;

        cycles = 0;
        idx = 0;
        while (idx < expPcQ.size() && cycles < runTimeout) begin
            @(negedge clk);
            checkPc(expPcQ[idx], pc);
            checkWord("a0", expA0Q[idx], a0);
            idx++;
            cycles++;
        end

        if (idx < expPcQ.size()) begin
            failWith("run did not cover the expected trace within the cycle limit");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: program_golden.txt
# P <instruction word hex>   program, loaded from word address 0
# E <pc hex> <a0 hex>        expected state after each executed cycle
P 00900513 # addi x10, x0, 9     (opOpImm)
P FFD00293 # addi x5, x0, -3
P 00A2A533 # slt x10, x5, x10    (opOp, f3Slt)
P 12345337 # lui x6, 0x12345     (opLui)
P 00A36533 # or x10, x6, x10
P 40550533 # sub x10, x10, x5    (f7Sub)
P 00657533 # and x10, x10, x6
P 00500013 # addi x0, x0, 5
P 00050533 # add x10, x10, x0
P 00A02423 # sw x10, 8(x0)       (opStore)
P 00100513 # addi x10, x0, 1
P 00802503 # lw x10, 8(x0)       (opLoad)
P 00650463 # beq x10, x6, +8     (opBranch, taken)
P 00700513 # addi x10, x0, 7     skipped
P 00651463 # bne x10, x6, +8     (not taken)
P 0080056F # jal x10, +8         (opJal)
P 00700513 # addi x10, x0, 7     skipped
P 0000006F # jal x0, 0           self loop
E 00000004 00000009
E 00000008 00000009
E 0000000C 00000001
E 00000010 00000001
E 00000014 12345001
E 00000018 12345004
E 0000001C 12345000
E 00000020 12345000
E 00000024 12345000
E 00000028 12345000
E 0000002C 00000001
E 00000030 12345000
E 00000038 12345000
E 0000003C 12345000
E 00000044 00000040
E 00000044 00000040
E 00000044 00000040
E 00000044 00000040

// File: tb.f
cpuPkg.sv
ctrlPkg.sv
ctrlIf.sv
programCounter.sv
instrMem.sv
instrDecoder.sv
alu.sv
regFile.sv
dataMem.sv
rvCore.sv
rvCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= rvCoreTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG := Testbench passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
